/* alu_decoder.sv */
`timescale 1ns/10ps

module alu_decoder import cpu_pkg::*; (
    input  alu_op_t             alu_op,
    input  logic [funct3_w-1:0] funct3,
    input  logic                op_5_xor_6,
    input  logic                funct7_5,
    output alu_ctrl_t           alu_control
);

    logic r_type_sub;

    // op[5]^op[6] is set only for the R-type opcode
    assign r_type_sub = op_5_xor_6 & funct7_5;

    always_comb begin
        case (alu_op)
            ALU_OP_ADD: alu_control = ADD; // loads, stores, addressing
            ALU_OP_SUB: alu_control = SUB; // branches
            ALU_OP_FUNCT: begin
                case (funct3)
                    3'b000:  alu_control = r_type_sub ? SUB : ADD;
                    3'b001:  alu_control = SLL;
                    3'b010:  alu_control = SLT;
                    3'b011:  alu_control = SLTU;
                    3'b100:  alu_control = XOR;
                    // srai and sra both carry bit 30
                    3'b101:  alu_control = funct7_5 ? SRA : SRL;
                    3'b110:  alu_control = OR;
                    3'b111:  alu_control = AND;
                    default: alu_control = ADD;
                endcase
            end
            default: alu_control = ADD;
        endcase
    end

endmodule

/* compile.f */
cpu_pkg.sv
extend.sv
alu_decoder.sv
forward_select.sv
dispatch.sv
dispatch_reg.sv
dispatch_stage.sv
tb_clock.sv
tb_dispatch_stage.sv

/* cpu_pkg.sv */
package cpu_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int funct3_w   = 3;
    localparam int rm_w       = 3;
    localparam int funct5_w   = 5;

    typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_src_t;

    typedef enum logic [1:0] {ALU_OP_ADD, ALU_OP_SUB, ALU_OP_FUNCT} alu_op_t;

    typedef enum logic [3:0] {
        ADD, SUB, AND, OR, XOR, SLT, SLTU, SLL, SRL, SRA
    } alu_ctrl_t;

    typedef enum logic [2:0] {
        RES_ALU, RES_MEM, RES_PC4, RES_IMM, RES_FMV_X_W, RES_FMV_W_X, RES_FPU
    } result_src_t;

    // select codes read by the operand muxes in dispatch
    typedef enum logic [2:0] {
        FWD_RF    = 3'b111,
        FWD_WB    = 3'b001,
        FWD_PC4_E = 3'b010, // jal/jalr ahead
        FWD_IMM_E = 3'b100, // lui ahead
        FWD_FMV_E = 3'b101  // fmv.x.w ahead
    } fwd_int_t;

    typedef enum logic [1:0] {
        FWD_F_RF    = 2'b00,
        FWD_F_WB    = 2'b01,
        FWD_F_MVX_E = 2'b11 // fmv.w.x ahead
    } fwd_fpu_t;

    typedef struct packed {
        logic                jump;
        logic                rs_fpu;
        logic                alu_src;
        logic                store_src;
        logic                reg_write;
        logic                fpu_reg_write;
        result_src_t         result_src;
        imm_src_t            imm_src;
        alu_op_t             alu_op;
        logic [funct3_w-1:0] funct3;
    } control_decode_t;

    typedef struct packed {
        logic [xlen-1:0]       instr;
        logic [xlen-1:0]       pc;
        logic [xlen-1:0]       pc_plus4;
        logic [reg_addr_w-1:0] rs1;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs3;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       rd1;
        logic [xlen-1:0]       rd2;
        logic [xlen-1:0]       fpu_rd1;
        logic [xlen-1:0]       fpu_rd2;
        logic [xlen-1:0]       fpu_rd3;
        logic [rm_w-1:0]       rm;
        logic [funct5_w-1:0]   funct5;
    } data_decode_t;

    typedef struct packed {
        logic        jump;
        logic        rs_fpu;
        logic        alu_src;
        logic        store_src;
        logic        reg_write;
        logic        fpu_reg_write;
        result_src_t result_src;
        alu_ctrl_t   alu_control;
    } control_dispatch_t;

    typedef struct packed {
        logic [xlen-1:0]       pc;
        logic [xlen-1:0]       pc_plus4;
        logic [reg_addr_w-1:0] rs1;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rs3;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       imm_ext;
        logic [xlen-1:0]       rd1;
        logic [xlen-1:0]       rd2;
        logic [xlen-1:0]       fpu_rd1;
        logic [xlen-1:0]       fpu_rd2;
        logic [xlen-1:0]       fpu_rd3;
        logic [rm_w-1:0]       rm;
        logic [funct5_w-1:0]   funct5;
    } data_dispatch_t;

    typedef struct packed {
        logic [reg_addr_w-1:0] rd_e;
        logic                  reg_write_e;
        logic                  fpu_reg_write_e;
        result_src_t           result_src_e;
        logic [xlen-1:0]       pc_plus4_e;
        logic [xlen-1:0]       imm_ext_e;
        logic [xlen-1:0]       rd1_e;
        logic [xlen-1:0]       fpu_rd1_e;
    } exec_fwd_t;

    typedef struct packed {
        logic [reg_addr_w-1:0] rd_w;
        logic                  reg_write_w;
        logic                  fpu_reg_write_w;
        logic [xlen-1:0]       result_w;
    } wb_fwd_t;

endpackage

/* dispatch.sv */
`timescale 1ns/10ps

module dispatch import cpu_pkg::*; (
    input  control_decode_t   control_decode,
    input  data_decode_t      data_decode,
    input  exec_fwd_t         exec_fwd,
    input  wb_fwd_t           wb_fwd,
    input  fwd_int_t          forward_rd1,
    input  fwd_int_t          forward_rd2,
    input  fwd_fpu_t          forward_fpu_rd1,
    input  fwd_fpu_t          forward_fpu_rd2,
    input  fwd_fpu_t          forward_fpu_rd3,
    output control_dispatch_t control_dispatch,
    output data_dispatch_t    data_dispatch
);

    logic [xlen-1:0] imm_ext;
    alu_ctrl_t       alu_control;

    function automatic logic [xlen-1:0] int_mux(input fwd_int_t sel,
                                                input logic [xlen-1:0] rf_val,
                                                input exec_fwd_t e,
                                                input wb_fwd_t w);
        case (sel)
            FWD_WB:    int_mux = w.result_w;
            FWD_PC4_E: int_mux = e.pc_plus4_e;
            FWD_IMM_E: int_mux = e.imm_ext_e;
            FWD_FMV_E: int_mux = e.fpu_rd1_e;
            default:   int_mux = rf_val;
        endcase
    endfunction

    function automatic logic [xlen-1:0] fpu_mux(input fwd_fpu_t sel,
                                                input logic [xlen-1:0] rf_val,
                                                input exec_fwd_t e,
                                                input wb_fwd_t w);
        case (sel)
            FWD_F_WB:    fpu_mux = w.result_w;
            FWD_F_MVX_E: fpu_mux = e.rd1_e; // integer source of fmv.w.x
            default:     fpu_mux = rf_val;
        endcase
    endfunction

    extend u_extend (
        .instr   (data_decode.instr),
        .imm_src (control_decode.imm_src),
        .imm_ext (imm_ext)
    );

    alu_decoder u_alu_decoder (
        .alu_op      (control_decode.alu_op),
        .funct3      (control_decode.funct3),
        .op_5_xor_6  (data_decode.instr[5] ^ data_decode.instr[6]),
        .funct7_5    (data_decode.instr[30]),
        .alu_control (alu_control)
    );

    always_comb begin
        control_dispatch.jump          = control_decode.jump;
        control_dispatch.rs_fpu        = control_decode.rs_fpu;
        control_dispatch.alu_src       = control_decode.alu_src;
        control_dispatch.store_src     = control_decode.store_src;
        control_dispatch.reg_write     = control_decode.reg_write;
        control_dispatch.fpu_reg_write = control_decode.fpu_reg_write;
        control_dispatch.result_src    = control_decode.result_src;
        control_dispatch.alu_control   = alu_control;
    end

    always_comb begin
        data_dispatch.pc       = data_decode.pc;
        data_dispatch.pc_plus4 = data_decode.pc_plus4;
        data_dispatch.rs1      = data_decode.rs1;
        data_dispatch.rs2      = data_decode.rs2;
        data_dispatch.rs3      = data_decode.rs3;
        data_dispatch.rd       = data_decode.rd;
        data_dispatch.imm_ext  = imm_ext;
        data_dispatch.rd1      = int_mux(forward_rd1, data_decode.rd1, exec_fwd, wb_fwd);
        data_dispatch.rd2      = int_mux(forward_rd2, data_decode.rd2, exec_fwd, wb_fwd);
        data_dispatch.fpu_rd1  = fpu_mux(forward_fpu_rd1, data_decode.fpu_rd1, exec_fwd, wb_fwd);
        data_dispatch.fpu_rd2  = fpu_mux(forward_fpu_rd2, data_decode.fpu_rd2, exec_fwd, wb_fwd);
        data_dispatch.fpu_rd3  = fpu_mux(forward_fpu_rd3, data_decode.fpu_rd3, exec_fwd, wb_fwd);
        data_dispatch.rm       = data_decode.rm;
        data_dispatch.funct5   = data_decode.funct5;
    end

endmodule

/* dispatch_reg.sv */
`timescale 1ns/10ps

module dispatch_reg import cpu_pkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic            stall,
    input  logic            flush,
    input  control_decode_t control_decode,
    input  data_decode_t    data_decode,
    output control_decode_t control_q,
    output data_decode_t    data_q,
    output logic            in_dispatch
);

    // flush beats stall on the control side
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            control_q   <= '0; // bubble with no writes and no jump
            in_dispatch <= 1'b0;
        end else if (!stall) begin
            control_q   <= control_decode;
            in_dispatch <= 1'b1;
        end
    end

    // payload only follows the stall
    always_ff @(posedge clk) begin
        if (!stall)
            data_q <= data_decode;
    end

endmodule

/* dispatch_stage.sv */
`timescale 1ns/10ps

module dispatch_stage import cpu_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              stall,
    input  logic              flush,
    input  control_decode_t   control_decode,
    input  data_decode_t      data_decode,
    input  exec_fwd_t         exec_fwd,
    input  wb_fwd_t           wb_fwd,
    output control_dispatch_t control_dispatch,
    output data_dispatch_t    data_dispatch,
    output logic              in_dispatch
);

    control_decode_t control_q;
    data_decode_t    data_q;
    fwd_int_t        forward_rd1;
    fwd_int_t        forward_rd2;
    fwd_fpu_t        forward_fpu_rd1;
    fwd_fpu_t        forward_fpu_rd2;
    fwd_fpu_t        forward_fpu_rd3;

    dispatch_reg u_dispatch_reg (
        .clk            (clk),
        .reset          (reset),
        .stall          (stall),
        .flush          (flush),
        .control_decode (control_decode),
        .data_decode    (data_decode),
        .control_q      (control_q),
        .data_q         (data_q),
        .in_dispatch    (in_dispatch)
    );

    forward_select u_forward_select (
        .rs1             (data_q.rs1),
        .rs2             (data_q.rs2),
        .rs3             (data_q.rs3),
        .rs_fpu          (control_q.rs_fpu),
        .exec_fwd        (exec_fwd),
        .wb_fwd          (wb_fwd),
        .forward_rd1     (forward_rd1),
        .forward_rd2     (forward_rd2),
        .forward_fpu_rd1 (forward_fpu_rd1),
        .forward_fpu_rd2 (forward_fpu_rd2),
        .forward_fpu_rd3 (forward_fpu_rd3)
    );

    dispatch u_dispatch (
        .control_decode   (control_q),
        .data_decode      (data_q),
        .exec_fwd         (exec_fwd),
        .wb_fwd           (wb_fwd),
        .forward_rd1      (forward_rd1),
        .forward_rd2      (forward_rd2),
        .forward_fpu_rd1  (forward_fpu_rd1),
        .forward_fpu_rd2  (forward_fpu_rd2),
        .forward_fpu_rd3  (forward_fpu_rd3),
        .control_dispatch (control_dispatch),
        .data_dispatch    (data_dispatch)
    );

endmodule

/* dispatch_tests.txt */
# st fl rs_fpu rw imm_src alu_op f3 instr rs1 rs2 rs3 | rd_e rw_e frw_e rsrc_e rd_w rw_w frw_w
# expected: in_dispatch imm_ext alu_control rd1 rd2 fpu_rd1 fpu_rd2 fpu_rd3 reg_write
0 0 0 1 0 2 0 ffb08293 1 0 0 0 0 0 0 0 0 0 1 fffffffb 0 11110001 22220002 f1f10001 f2f20002 f3f30003 1
0 0 0 1 0 2 0 402081b3 1 2 0 1 1 0 2 2 1 0 1 00000402 1 00002004 0bbb0001 f1f10001 f2f20002 f3f30003 1
0 0 0 0 1 0 2 fe20ac23 1 2 0 1 1 0 3 1 1 0 1 fffffff8 0 abcde000 22220002 f1f10001 f2f20002 f3f30003 0
0 0 0 0 2 1 0 fe2088e3 0 2 0 0 1 0 2 0 1 0 1 fffffff0 1 11110001 22220002 f1f10001 f2f20002 f3f30003 0
0 0 0 1 3 0 0 123453b7 9 5 0 5 1 0 4 9 1 0 1 12345000 0 0bbb0001 0fef0001 f1f10001 f2f20002 f3f30003 1
0 0 0 1 4 0 0 001000ef 3 0 0 3 1 0 0 3 1 1 1 00000800 0 0bbb0001 22220002 f1f10001 f2f20002 f3f30003 1
0 0 0 1 0 2 5 4062d233 5 6 0 5 0 0 2 6 0 0 1 00000406 9 11110001 22220002 f1f10001 f2f20002 f3f30003 1
0 0 0 1 0 2 3 7ff4b413 9 0 0 0 0 0 0 0 0 0 1 000007ff 6 11110001 22220002 f1f10001 f2f20002 f3f30003 1
0 0 0 1 0 2 5 4030d093 1 0 0 0 0 0 0 0 0 0 1 00000403 9 11110001 22220002 f1f10001 f2f20002 f3f30003 1
0 0 0 1 0 2 0 40000113 0 0 0 0 0 0 0 0 0 0 1 00000400 0 11110001 22220002 f1f10001 f2f20002 f3f30003 1
0 0 1 0 0 2 1 12300043 1 2 3 1 1 1 5 3 1 1 1 00000123 7 11110001 22220002 0e1e0001 f2f20002 0bbb0001 0
0 0 1 0 0 2 2 fff00053 0 4 0 4 0 1 6 0 0 1 1 ffffffff 5 11110001 22220002 0bbb0001 f2f20002 0bbb0001 0
0 0 1 0 1 2 4 80000f87 7 8 9 9 0 1 5 9 0 1 1 fffff81f 4 11110001 22220002 f1f10001 f2f20002 0e1e0001 0
1 0 0 1 3 1 0 deadbeef 1 2 3 0 0 0 0 0 0 0 1 fffff81f 4 11110001 22220002 f1f10001 f2f20002 f3f30003 0
0 0 0 1 0 2 6 00c5e6b3 b c 0 0 0 0 0 0 0 0 1 0000000c 3 11110001 22220002 f1f10001 f2f20002 f3f30003 1
0 1 0 1 0 2 7 00f77733 e f 0 0 0 0 0 0 0 0 0 0000000f 0 11110001 22220002 f1f10001 f2f20002 f3f30003 0
0 0 0 1 0 2 7 00f77733 e f 0 0 0 0 0 0 0 0 1 0000000f 2 11110001 22220002 f1f10001 f2f20002 f3f30003 1
1 1 0 1 3 1 0 11111111 1 2 3 0 0 0 0 0 0 0 0 0000000f 0 11110001 22220002 f1f10001 f2f20002 f3f30003 0
0 0 0 1 0 2 5 003150b3 2 3 0 0 0 0 0 0 0 0 1 00000003 8 11110001 22220002 f1f10001 f2f20002 f3f30003 1
0 0 0 1 4 0 0 ffdff06f 6 6 0 6 1 0 2 0 0 0 1 fffffffc 0 00002004 00002004 f1f10001 f2f20002 f3f30003 1

/* extend.sv */
`timescale 1ns/10ps

module extend import cpu_pkg::*; (
    input  logic [xlen-1:0] instr,
    input  imm_src_t        imm_src,
    output logic [xlen-1:0] imm_ext
);

    logic sign;

    assign sign = instr[xlen-1];

    always_comb begin
        case (imm_src)
            IMM_I: imm_ext = {{(xlen-12){sign}}, instr[31:20]};
            IMM_S: imm_ext = {{(xlen-12){sign}}, instr[31:25], instr[11:7]};
            // branch offset with bit 0 always zero
            IMM_B: begin
                imm_ext = {{(xlen-12){sign}}, instr[7], instr[30:25],
                           instr[11:8], 1'b0};
            end
            IMM_U: imm_ext = {instr[31:12], 12'b0}; // lui/auipc upper bits
            IMM_J: begin
                imm_ext = {{(xlen-20){sign}}, instr[19:12], instr[20],
                           instr[30:21], 1'b0};
            end
            default: imm_ext = '0;
        endcase
    end

endmodule

/* forward_select.sv */
`timescale 1ns/10ps

module forward_select import cpu_pkg::*; (
    input  logic [reg_addr_w-1:0] rs1,
    input  logic [reg_addr_w-1:0] rs2,
    input  logic [reg_addr_w-1:0] rs3,
    input  logic                  rs_fpu,
    input  exec_fwd_t             exec_fwd,
    input  wb_fwd_t               wb_fwd,
    output fwd_int_t              forward_rd1,
    output fwd_int_t              forward_rd2,
    output fwd_fpu_t              forward_fpu_rd1,
    output fwd_fpu_t              forward_fpu_rd2,
    output fwd_fpu_t              forward_fpu_rd3
);

    function automatic fwd_int_t int_sel(input logic [reg_addr_w-1:0] rs,
                                         input exec_fwd_t e,
                                         input wb_fwd_t w);
        logic e_hit;
        logic w_hit;
        e_hit   = e.reg_write_e && (e.rd_e == rs);
        w_hit   = w.reg_write_w && (w.rd_w == rs);
        int_sel = FWD_RF;
        if (rs != '0) begin // x0 reads zero
            if (e_hit && e.result_src_e == RES_PC4)
                int_sel = FWD_PC4_E;
            else if (e_hit && e.result_src_e == RES_IMM)
                int_sel = FWD_IMM_E;
            else if (e_hit && e.result_src_e == RES_FMV_X_W)
                int_sel = FWD_FMV_E;
            else if (w_hit)
                int_sel = FWD_WB;
        end
    endfunction

    function automatic fwd_fpu_t fpu_sel(input logic [reg_addr_w-1:0] rs,
                                         input exec_fwd_t e,
                                         input wb_fwd_t w);
        fpu_sel = FWD_F_RF;
        if (e.fpu_reg_write_e && e.rd_e == rs && e.result_src_e == RES_FMV_W_X)
            fpu_sel = FWD_F_MVX_E;
        else if (w.fpu_reg_write_w && w.rd_w == rs) // f0 is a real register
            fpu_sel = FWD_F_WB;
    endfunction

    // integer slots only for integer sources, fpu slots only for fpu sources
    assign forward_rd1     = rs_fpu ? FWD_RF : int_sel(rs1, exec_fwd, wb_fwd);
    assign forward_rd2     = rs_fpu ? FWD_RF : int_sel(rs2, exec_fwd, wb_fwd);
    assign forward_fpu_rd1 = rs_fpu ? fpu_sel(rs1, exec_fwd, wb_fwd) : FWD_F_RF;
    assign forward_fpu_rd2 = rs_fpu ? fpu_sel(rs2, exec_fwd, wb_fwd) : FWD_F_RF;
    assign forward_fpu_rd3 = rs_fpu ? fpu_sel(rs3, exec_fwd, wb_fwd) : FWD_F_RF;

endmodule

/* run_sim.sh */
#!/bin/bash
# build and run the dispatch stage testbench with Verilator

rm -f sim.log

verilator --binary --timing -f compile.f --top-module tb_dispatch_stage -o sim_dispatch \
    && ./obj_dir/sim_dispatch > sim.log 2>&1

cat sim.log 2>/dev/null

grep -q "TEST PASSED" sim.log && exit 0 || exit 1

/* tb_clock.sv */
`timescale 1ns/10ps

module tb_clock (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #2 clk = ~clk; // 4 ns period

endmodule

/* tb_dispatch_stage.sv */
`timescale 1ns/10ps

module tb_dispatch_stage import cpu_pkg::*; ();

    // register file and later-stage values fixed for every vector
    localparam logic [31:0] rf_rd1   = 32'h1111_0001;
    localparam logic [31:0] rf_rd2   = 32'h2222_0002;
    localparam logic [31:0] rf_f1    = 32'hf1f1_0001;
    localparam logic [31:0] rf_f2    = 32'hf2f2_0002;
    localparam logic [31:0] rf_f3    = 32'hf3f3_0003;
    localparam logic [31:0] e_pc4    = 32'h0000_2004;
    localparam logic [31:0] e_imm    = 32'habcd_e000;
    localparam logic [31:0] e_rd1    = 32'h0e1e_0001;
    localparam logic [31:0] e_fpu    = 32'h0fef_0001;
    localparam logic [31:0] w_result = 32'h0bbb_0001;
    localparam int          max_vec  = 64;
    localparam int          n_cols   = 27;

    logic              clk;
    logic              reset;
    logic              stall;
    logic              flush;
    control_decode_t   control_decode;
    data_decode_t      data_decode;
    exec_fwd_t         exec_fwd;
    wb_fwd_t           wb_fwd;
    control_dispatch_t control_dispatch;
    data_dispatch_t    data_dispatch;
    logic              in_dispatch;

    logic [31:0]       vecs [0:max_vec-1][0:n_cols-1];
    int                nvec   = 0;
    int                limit  = 0;
    int                cycles = 0;
    control_decode_t   held_ctrl; // what the pipeline register should hold
    data_decode_t      held_data;

    tb_clock u_clock (
        .clk (clk)
    );

    dispatch_stage u_dut (
        .clk              (clk),
        .reset            (reset),
        .stall            (stall),
        .flush            (flush),
        .control_decode   (control_decode),
        .data_decode      (data_decode),
        .exec_fwd         (exec_fwd),
        .wb_fwd           (wb_fwd),
        .control_dispatch (control_dispatch),
        .data_dispatch    (data_dispatch),
        .in_dispatch      (in_dispatch)
    );

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED t=%0t %s: got %b expected %b", $time, name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "bit mismatch");
        end
    endtask

    task automatic check_ctrl(input control_dispatch_t got, input control_dispatch_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED t=%0t control_dispatch: got %h expected %h",
                     $time, got, exp);
            $display("TEST FAILED");
            $fatal(1, "control mismatch");
        end
    endtask

    task automatic check_data(input data_dispatch_t got, input data_dispatch_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED t=%0t data_dispatch: got %h expected %h",
                     $time, got, exp);
            $display("TEST FAILED");
            $fatal(1, "data mismatch");
        end
    endtask

    task automatic load_vectors();
        int          fd;
        int          code;
        string       line;
        logic [31:0] f [0:n_cols-1];
        fd = $fopen("dispatch_tests.txt", "r");
        if (fd == 0)
            abort_run("could not open dispatch_tests.txt");
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code > 0 && line.len() > 8 && line.getc(0) != "#") begin
                code = $sscanf(line,
                    "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
                    f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18],
                    f[19], f[20], f[21], f[22], f[23], f[24], f[25], f[26]);
                if (code != n_cols)
                    abort_run("malformed line in dispatch_tests.txt");
                if (nvec >= max_vec)
                    abort_run("too many vectors in dispatch_tests.txt");
                for (int k = 0; k < n_cols; k++)
                    vecs[nvec][k] = f[k];
                nvec++;
            end
        end
        $fclose(fd);
        if (nvec == 0)
            abort_run("no vectors found in dispatch_tests.txt");
    endtask

    task automatic drive_decode(input int i);
        control_decode_t c;
        data_decode_t    d;
        c               = '0;
        c.jump          = i[0]; // spare control bits follow the vector index
        c.rs_fpu        = vecs[i][2][0];
        c.alu_src       = i[1];
        c.store_src     = i[2];
        c.reg_write     = vecs[i][3][0];
        c.fpu_reg_write = i[3];
        c.result_src    = result_src_t'(3'(i % 7));
        c.imm_src       = imm_src_t'(vecs[i][4][2:0]);
        c.alu_op        = alu_op_t'(vecs[i][5][1:0]);
        c.funct3        = vecs[i][6][2:0];
        d.instr      = vecs[i][7];
        d.pc         = 32'h1000 + 32'(i) * 4;
        d.pc_plus4   = d.pc + 4;
        d.rs1        = vecs[i][8][4:0];
        d.rs2        = vecs[i][9][4:0];
        d.rs3        = vecs[i][10][4:0];
        d.rd         = 5'(i);
        d.rd1        = rf_rd1;
        d.rd2        = rf_rd2;
        d.fpu_rd1    = rf_f1;
        d.fpu_rd2    = rf_f2;
        d.fpu_rd3    = rf_f3;
        d.rm         = 3'(i);
        d.funct5     = 5'(i + 3);
        stall          = vecs[i][0][0];
        flush          = vecs[i][1][0];
        control_decode = c;
        data_decode    = d;
        if (flush)
            held_ctrl = '0; // bubble
        else if (!stall)
            held_ctrl = c;
        if (!stall)
            held_data = d;
    endtask

    task automatic drive_forwarding(input int i);
        exec_fwd.rd_e            = vecs[i][11][4:0];
        exec_fwd.reg_write_e     = vecs[i][12][0];
        exec_fwd.fpu_reg_write_e = vecs[i][13][0];
        exec_fwd.result_src_e    = result_src_t'(vecs[i][14][2:0]);
        exec_fwd.pc_plus4_e      = e_pc4;
        exec_fwd.imm_ext_e       = e_imm;
        exec_fwd.rd1_e           = e_rd1;
        exec_fwd.fpu_rd1_e       = e_fpu;
        wb_fwd.rd_w              = vecs[i][15][4:0];
        wb_fwd.reg_write_w       = vecs[i][16][0];
        wb_fwd.fpu_reg_write_w   = vecs[i][17][0];
        wb_fwd.result_w          = w_result;
    endtask

    task automatic check_vector(input int i);
        control_dispatch_t exp_c;
        data_dispatch_t    exp_d;
        exp_c.jump          = held_ctrl.jump;
        exp_c.rs_fpu        = held_ctrl.rs_fpu;
        exp_c.alu_src       = held_ctrl.alu_src;
        exp_c.store_src     = held_ctrl.store_src;
        exp_c.reg_write     = vecs[i][26][0];
        exp_c.fpu_reg_write = held_ctrl.fpu_reg_write;
        exp_c.result_src    = held_ctrl.result_src;
        exp_c.alu_control   = alu_ctrl_t'(vecs[i][20][3:0]);
        exp_d.pc            = held_data.pc;
        exp_d.pc_plus4      = held_data.pc_plus4;
        exp_d.rs1           = held_data.rs1;
        exp_d.rs2           = held_data.rs2;
        exp_d.rs3           = held_data.rs3;
        exp_d.rd            = held_data.rd;
        exp_d.imm_ext       = vecs[i][19];
        exp_d.rd1           = vecs[i][21];
        exp_d.rd2           = vecs[i][22];
        exp_d.fpu_rd1       = vecs[i][23];
        exp_d.fpu_rd2       = vecs[i][24];
        exp_d.fpu_rd3       = vecs[i][25];
        exp_d.rm            = held_data.rm;
        exp_d.funct5        = held_data.funct5;
        check_bit("in_dispatch", in_dispatch, vecs[i][18][0]);
        check_bit("reg_write", control_dispatch.reg_write, vecs[i][26][0]);
        check_ctrl(control_dispatch, exp_c);
        check_data(data_dispatch, exp_d);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles > limit) begin
            $display("timeout after %0d cycles, the vector loop did not finish", cycles);
            $display("TEST FAILED");
            $fatal(1, "timeout");
        end
    end

    initial begin
        reset                        = 1'b1;
        stall                        = 1'b0;
        flush                        = 1'b0;
        control_decode               = '0;
        control_decode.jump          = 1'b1; // pending writes that reset must drop
        control_decode.reg_write     = 1'b1;
        control_decode.fpu_reg_write = 1'b1;
        data_decode                  = '0;
        exec_fwd                     = '0;
        wb_fwd                       = '0;
        held_ctrl                    = '0;
        held_data                    = '0;
        load_vectors();
        limit = nvec * 3 + 20;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        #1;
        check_bit("in_dispatch", in_dispatch, 1'b0); // bubble left by reset
        check_bit("reg_write", control_dispatch.reg_write, 1'b0);
        check_bit("fpu_reg_write", control_dispatch.fpu_reg_write, 1'b0);
        check_bit("jump", control_dispatch.jump, 1'b0);
        for (int i = 0; i < nvec; i++) begin
            @(negedge clk);
            drive_decode(i);
            @(negedge clk);
            drive_forwarding(i);
            #1;
            check_vector(i);
        end
        $display("TEST PASSED");
        $finish;
    end

endmodule
